// ==== all.f ====
+incdir+src
src/dcache_pkg.sv
src/cache_ifs.sv
src/tag_store.sv
src/data_store.sv
src/line_state.sv
src/cache_ctrl.sv
src/dcache_top.sv
verification/mem_model.sv
verification/tb_dcache.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module tb_dcache -o tb_dcache_sim &&
./obj_dir/tb_dcache_sim || exit 1

// ==== src/cache_ctrl.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module cache_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req,
    input  logic                     wr,
    input  logic [`DC_STRB_W-1:0]    sel,
    input  dcache_pkg::dcache_addr_u addr,
    input  logic [`DC_WORD_W-1:0]    wdata,
    output logic                     addr_ok,
    output logic                     data_ok,
    output logic [`DC_WORD_W-1:0]    rdata,
    output dcache_pkg::dcache_addr_u mem_ar_addr,
    output logic                     mem_ar_valid,
    input  logic                     mem_ar_ready,
    input  logic [`DC_WORD_W-1:0]    mem_r_data,
    input  logic                     mem_r_valid,
    input  logic                     mem_r_last,
    output dcache_pkg::dcache_addr_u mem_aw_addr,
    output logic                     mem_aw_valid,
    input  logic                     mem_aw_ready,
    output logic [`DC_WORD_W-1:0]    mem_w_data,
    output logic                     mem_w_valid,
    input  logic                     mem_w_ready,
    output logic                     mem_w_last,
    input  logic                     mem_b_valid,
    array_if.ctrl                    arr,
    line_state_if.ctrl               ls
);
    import dcache_pkg::*;

    localparam logic [3:0] st_idle    = 4'd0;
    localparam logic [3:0] st_lookup  = 4'd1;
    localparam logic [3:0] st_wb_addr = 4'd2;
    localparam logic [3:0] st_wb_data = 4'd3;
    localparam logic [3:0] st_wb_resp = 4'd4;
    localparam logic [3:0] st_rf_addr = 4'd5;
    localparam logic [3:0] st_rf_data = 4'd6;
    localparam logic [3:0] st_update  = 4'd7;
    localparam logic [3:0] st_respond = 4'd8;

    localparam logic [`DC_OFFSET_W-1:0] last_beat = `DC_OFFSET_W'(`DC_LINE_WORDS - 1);

    logic [3:0]              state;
    dcache_addr_u            req_r;
    logic                    wr_r;
    logic [`DC_WORD_W-1:0]   wdata_r;
    logic [`DC_STRB_W-1:0]   sel_r;
    logic [`DC_OFFSET_W-1:0] wb_cnt;
    logic [`DC_OFFSET_W-1:0] rf_cnt;
    logic [`DC_WORD_W-1:0]   fill_word;
    logic                    hit;
    logic                    accept;
    logic                    rf_beat;
    logic                    wb_beat;
    logic [3:0]              w_beats;

    assign accept  = (state == st_idle) && req;
    assign hit     = arr.hit0 || arr.hit1;
    assign rf_beat = (state == st_rf_data) && mem_r_valid;
    assign wb_beat = mem_w_valid && mem_w_ready;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_r   <= addr;
            wr_r    <= wr;
            wdata_r <= wdata;
            sel_r   <= sel;
        end
        // requested word as it passes by on refill
        if (rf_beat && rf_cnt == req_r.f.offset) begin
            fill_word <= mem_r_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= st_idle;
            wb_cnt <= '0;
            rf_cnt <= '0;
        end else begin
            if (state == st_wb_addr) begin
                wb_cnt <= '0;
            end else if (wb_beat) begin
                wb_cnt <= wb_cnt + 1'b1;
            end
            if (state == st_rf_addr) begin
                rf_cnt <= '0;
            end else if (rf_beat) begin
                rf_cnt <= rf_cnt + 1'b1;
            end

            case (state)
                st_idle: begin
                    if (req) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    if (hit) begin
                        state <= st_idle;
                    end else if (ls.victim_dirty) begin
                        state <= st_wb_addr;
                    end else begin
                        state <= st_rf_addr;
                    end
                end
                st_wb_addr: begin
                    if (mem_aw_ready) begin
                        state <= st_wb_data;
                    end
                end
                st_wb_data: begin
                    if (wb_beat && mem_w_last) begin
                        state <= st_wb_resp;
                    end
                end
                st_wb_resp: begin
                    if (mem_b_valid) begin
                        state <= st_rf_addr;
                    end
                end
                st_rf_addr: begin
                    if (mem_ar_ready) begin
                        state <= st_rf_data;
                    end
                end
                st_rf_data: begin
                    if (mem_r_valid && mem_r_last) begin
                        state <= st_update;
                    end
                end
                st_update:  state <= st_respond;
                st_respond: state <= st_idle;
                default:    state <= st_idle;
            endcase
        end
    end

    // index comes straight from the cpu while idle
    always_comb begin
        arr.index     = (state == st_idle) ? addr.f.index : req_r.f.index;
        arr.offset    = (state == st_rf_data) ? rf_cnt : req_r.f.offset;
        arr.wtag      = req_r.f.tag;
        arr.tag_we    = (state == st_update);
        arr.way       = (state == st_lookup) ? arr.hit1 : ls.victim_way;
        arr.wb_cnt    = wb_cnt;
        arr.data_we   = 1'b0;
        arr.data_strb = sel_r;
        arr.wdata     = wdata_r;
        case (state)
            st_lookup: arr.data_we = hit && wr_r;
            st_rf_data: begin
                arr.data_we   = mem_r_valid;
                arr.data_strb = '1;
                arr.wdata     = mem_r_data;
            end
            // store merges on top of the refilled line
            st_update: arr.data_we = wr_r;
            default: ;
        endcase
    end

    always_comb begin
        ls.index      = req_r.f.index;
        ls.touch      = (state == st_lookup) && hit;
        ls.hit_way    = arr.hit1;
        ls.mark_dirty = (state == st_lookup) && hit && wr_r;
        ls.fill       = (state == st_update);
        ls.fill_dirty = wr_r;
    end

    // line-aligned burst addresses
    always_comb begin
        mem_ar_addr            = req_r;
        mem_ar_addr.f.offset   = '0;
        mem_ar_addr.f.byte_off = '0;
        mem_aw_addr            = req_r;
        mem_aw_addr.f.tag      = arr.victim_tag;
        mem_aw_addr.f.offset   = '0;
        mem_aw_addr.f.byte_off = '0;
    end

    assign mem_ar_valid = (state == st_rf_addr);
    assign mem_aw_valid = (state == st_wb_addr);
    assign mem_w_valid  = (state == st_wb_data);
    assign mem_w_data   = arr.wb_word;
    assign mem_w_last   = mem_w_valid && (wb_cnt == last_beat);

    assign addr_ok = (state == st_idle);
    assign data_ok = ((state == st_lookup) && hit) || (state == st_respond);
    assign rdata   = (state == st_lookup) ? arr.hit_word : fill_word;

    // write beats accepted since the write address handshake
    always_ff @(posedge clk) begin
        if (rst || (mem_aw_valid && mem_aw_ready)) begin
            w_beats <= '0;
        end else if (wb_beat) begin
            w_beats <= w_beats + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(data_ok && addr_ok));

    // last beat only after seven accepted beats of this burst
    assert property (@(posedge clk) disable iff (rst)
        mem_w_last |-> mem_w_valid && w_beats == 4'd7);

endmodule

// ==== src/cache_ifs.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

// controller to tag and data arrays
interface array_if;
    logic [`DC_INDEX_W-1:0]  index;
    logic [`DC_OFFSET_W-1:0] offset;
    logic [`DC_TAG_W-1:0]    wtag;
    logic                    tag_we;
    logic                    way;
    logic                    data_we;
    logic [`DC_STRB_W-1:0]   data_strb;
    logic [`DC_WORD_W-1:0]   wdata;
    logic [`DC_OFFSET_W-1:0] wb_cnt;
    logic                    hit0;
    logic                    hit1;
    logic [`DC_TAG_W-1:0]    victim_tag;
    logic [`DC_WORD_W-1:0]   hit_word;
    logic [`DC_WORD_W-1:0]   wb_word;

    modport ctrl (
        output index, offset, wtag, tag_we, way, data_we, data_strb, wdata, wb_cnt,
        input  hit0, hit1, victim_tag, hit_word, wb_word
    );
    modport tags (
        input  index, wtag, tag_we, way,
        output hit0, hit1, victim_tag
    );
    modport data (
        input  index, offset, way, data_we, data_strb, wdata, wb_cnt, hit1,
        output hit_word, wb_word
    );
endinterface

// controller to per-set lru and dirty state
interface line_state_if;
    logic [`DC_INDEX_W-1:0] index;
    logic                   touch;
    logic                   hit_way;
    logic                   mark_dirty;
    logic                   fill;
    logic                   fill_dirty;
    logic                   victim_way;
    logic                   victim_dirty;

    modport ctrl (
        output index, touch, hit_way, mark_dirty, fill, fill_dirty,
        input  victim_way, victim_dirty
    );
    modport state (
        input  index, touch, hit_way, mark_dirty, fill, fill_dirty,
        output victim_way, victim_dirty
    );
endinterface

// ==== src/data_store.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module data_store (
    input  logic  clk,
    array_if.data arr
);
    logic [`DC_WORD_W-1:0] lines [2][`DC_SETS][`DC_LINE_WORDS];
    logic [`DC_WORD_W-1:0] line_q [2][`DC_LINE_WORDS];

    // byte-lane write into the addressed word
    always_ff @(posedge clk) begin
        for (int b = 0; b < `DC_STRB_W; b++) begin
            if (arr.data_we && arr.data_strb[b]) begin
                lines[arr.way][arr.index][arr.offset][8*b +: 8] <= arr.wdata[8*b +: 8];
            end
        end
    end

    // whole line of both ways, one cycle after the index
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            for (int k = 0; k < `DC_LINE_WORDS; k++) begin
                line_q[w][k] <= lines[w][arr.index][k];
            end
        end
    end

    // word selection
    assign arr.hit_word = line_q[arr.hit1][arr.offset];
    assign arr.wb_word  = line_q[arr.way][arr.wb_cnt];

    // a cpu store with no byte selected would still mark the line dirty
    assert property (@(posedge clk) arr.data_we |-> arr.data_strb != '0);

endmodule

// ==== src/dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// address and data
`define DC_ADDR_W      32
`define DC_WORD_W      32
`define DC_STRB_W      4

// address split, tag + index + offset + byte
`define DC_TAG_W       20
`define DC_INDEX_W     7
`define DC_OFFSET_W    3
`define DC_BYTE_W      2

// geometry
`define DC_SETS        128
`define DC_LINE_WORDS  8

`endif

// ==== src/dcache_pkg.sv ====
`include "dcache_consts.svh"

package dcache_pkg;

    // one address word, raw for the bus or split for the arrays
    typedef union packed {
        logic [`DC_ADDR_W-1:0] raw;
        struct packed {
            logic [`DC_TAG_W-1:0]    tag;
            logic [`DC_INDEX_W-1:0]  index;
            logic [`DC_OFFSET_W-1:0] offset;
            logic [`DC_BYTE_W-1:0]   byte_off;
        } f;
    } dcache_addr_u;

endpackage

// ==== src/dcache_top.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req,
    input  logic                   wr,
    input  logic [`DC_STRB_W-1:0]  sel,
    input  logic [`DC_ADDR_W-1:0]  addr,
    input  logic [`DC_WORD_W-1:0]  wdata,
    output logic                   addr_ok,
    output logic                   data_ok,
    output logic [`DC_WORD_W-1:0]  rdata,
    output logic [`DC_ADDR_W-1:0]  mem_ar_addr,
    output logic                   mem_ar_valid,
    input  logic                   mem_ar_ready,
    input  logic [`DC_WORD_W-1:0]  mem_r_data,
    input  logic                   mem_r_valid,
    input  logic                   mem_r_last,
    output logic [`DC_ADDR_W-1:0]  mem_aw_addr,
    output logic                   mem_aw_valid,
    input  logic                   mem_aw_ready,
    output logic [`DC_WORD_W-1:0]  mem_w_data,
    output logic                   mem_w_valid,
    input  logic                   mem_w_ready,
    output logic                   mem_w_last,
    input  logic                   mem_b_valid
);
    import dcache_pkg::*;

    dcache_addr_u ar_line;
    dcache_addr_u aw_line;

    array_if      arr_if ();
    line_state_if ls_if ();

    cache_ctrl cache_ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .wr           (wr),
        .sel          (sel),
        .addr         (addr),
        .wdata        (wdata),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .mem_ar_addr  (ar_line),
        .mem_ar_valid (mem_ar_valid),
        .mem_ar_ready (mem_ar_ready),
        .mem_r_data   (mem_r_data),
        .mem_r_valid  (mem_r_valid),
        .mem_r_last   (mem_r_last),
        .mem_aw_addr  (aw_line),
        .mem_aw_valid (mem_aw_valid),
        .mem_aw_ready (mem_aw_ready),
        .mem_w_data   (mem_w_data),
        .mem_w_valid  (mem_w_valid),
        .mem_w_ready  (mem_w_ready),
        .mem_w_last   (mem_w_last),
        .mem_b_valid  (mem_b_valid),
        .arr          (arr_if),
        .ls           (ls_if)
    );

    tag_store tag_store_i (
        .clk (clk),
        .rst (rst),
        .arr (arr_if)
    );

    data_store data_store_i (
        .clk (clk),
        .arr (arr_if)
    );

    line_state line_state_i (
        .clk (clk),
        .rst (rst),
        .ls  (ls_if)
    );

    assign mem_ar_addr = ar_line.raw;
    assign mem_aw_addr = aw_line.raw;

endmodule

// ==== src/line_state.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module line_state (
    input  logic        clk,
    input  logic        rst,
    line_state_if.state ls
);
    // lru bit names the way to evict next
    logic [`DC_SETS-1:0]      lru;
    logic [1:0][`DC_SETS-1:0] dirty;
    logic                     victim;

    assign victim          = lru[ls.index];
    assign ls.victim_way   = victim;
    assign ls.victim_dirty = dirty[victim][ls.index];

    always_ff @(posedge clk) begin
        if (rst) begin
            lru   <= '0;
            dirty <= '0;
        end else begin
            // hit points the lru at the other way
            if (ls.touch) begin
                lru[ls.index] <= ~ls.hit_way;
                if (ls.mark_dirty) begin
                    dirty[ls.hit_way][ls.index] <= 1'b1;
                end
            end
            // refill replaced the victim
            if (ls.fill) begin
                lru[ls.index]          <= ~victim;
                dirty[victim][ls.index] <= ls.fill_dirty;
            end
        end
    end

    // hits and fills belong to different requests
    assert property (@(posedge clk) disable iff (rst) !(ls.touch && ls.fill));

endmodule

// ==== src/tag_store.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module tag_store (
    input  logic  clk,
    input  logic  rst,
    array_if.tags arr
);
    logic [`DC_TAG_W-1:0]      tags [2][`DC_SETS];
    logic [1:0][`DC_SETS-1:0]  valid;
    logic [1:0][`DC_TAG_W-1:0] tag_q;
    logic [1:0]                valid_q;

    // tag ram, read-before-write at the same index
    always_ff @(posedge clk) begin
        if (arr.tag_we) begin
            tags[arr.way][arr.index] <= arr.wtag;
        end
        for (int w = 0; w < 2; w++) begin
            tag_q[w] <= tags[w][arr.index];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid   <= '0;
            valid_q <= '0;
        end else begin
            if (arr.tag_we) begin
                valid[arr.way][arr.index] <= 1'b1;
            end
            for (int w = 0; w < 2; w++) begin
                valid_q[w] <= valid[w][arr.index];
            end
        end
    end

    assign arr.hit0       = valid_q[0] && (tag_q[0] == arr.wtag);
    assign arr.hit1       = valid_q[1] && (tag_q[1] == arr.wtag);
    // tag of the way being evicted, for the write-back address
    assign arr.victim_tag = tag_q[arr.way];

    // a line is only ever filled into one way
    assert property (@(posedge clk) disable iff (rst) !(arr.hit0 && arr.hit1));

endmodule

// ==== verification/mem_model.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module mem_model (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`DC_ADDR_W-1:0] ar_addr,
    input  logic                  ar_valid,
    output logic                  ar_ready,
    output logic [`DC_WORD_W-1:0] r_data,
    output logic                  r_valid,
    output logic                  r_last,
    input  logic [`DC_ADDR_W-1:0] aw_addr,
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  logic [`DC_WORD_W-1:0] w_data,
    input  logic                  w_valid,
    output logic                  w_ready,
    input  logic                  w_last,
    output logic                  b_valid
);
    localparam int mem_words = 16384;

    logic [`DC_WORD_W-1:0] mem [mem_words];
    logic [13:0]           rd_ptr;
    logic [13:0]           wr_ptr;
    logic [3:0]            rd_left;
    logic                  rd_busy;
    logic                  wr_busy;
    int                    seed;

    function automatic logic [`DC_WORD_W-1:0] preset_word(input logic [13:0] widx);
        return {2'b10, widx, 2'b01, widx} ^ 32'h3c5a_0f0f;
    endfunction

    initial begin
        seed     = 32'h9621bcba;
        ar_ready = 1'b0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        r_valid  = 1'b0;
        r_last   = 1'b0;
        r_data   = '0;
        b_valid  = 1'b0;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = preset_word(14'(i));
        end
    end

    // each ready and each read beat stalls about one cycle in four
    always @(posedge clk) begin
        if (rst) begin
            ar_ready <= 1'b0;
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            r_valid  <= 1'b0;
            r_last   <= 1'b0;
            b_valid  <= 1'b0;
            rd_busy  <= 1'b0;
            wr_busy  <= 1'b0;
            rd_left  <= '0;
        end else begin
            ar_ready <= !rd_busy && (($random(seed) & 3) != 0);
            aw_ready <= !wr_busy && (($random(seed) & 3) != 0);
            w_ready  <= wr_busy && (($random(seed) & 3) != 0);
            r_valid  <= 1'b0;
            r_last   <= 1'b0;
            b_valid  <= 1'b0;
            if (ar_valid && ar_ready) begin
                ar_ready <= 1'b0;
                rd_busy  <= 1'b1;
                rd_ptr   <= ar_addr[15:2];
                rd_left  <= 4'd8;
            end
            if (rd_busy && (($random(seed) & 3) != 0)) begin
                r_valid <= 1'b1;
                r_data  <= mem[rd_ptr];
                r_last  <= (rd_left == 4'd1);
                rd_ptr  <= rd_ptr + 1'b1;
                rd_left <= rd_left - 1'b1;
                if (rd_left == 4'd1) begin
                    rd_busy <= 1'b0;
                end
            end
            if (aw_valid && aw_ready) begin
                aw_ready <= 1'b0;
                wr_busy  <= 1'b1;
                wr_ptr   <= aw_addr[15:2];
            end
            if (w_valid && w_ready) begin
                mem[wr_ptr] <= w_data;
                wr_ptr      <= wr_ptr + 1'b1;
                // response right after the last beat
                if (w_last) begin
                    wr_busy <= 1'b0;
                    w_ready <= 1'b0;
                    b_valid <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== verification/tb_dcache.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module tb_dcache;
    import dcache_pkg::*;

    localparam int directed_ops = 20;
    localparam int random_ops   = 300;
    localparam int mem_words    = 16384;
    localparam int watchdog_ns  = (directed_ops + random_ops) * 200 * 4 + 16 * 4;

    logic                  clk;
    logic                  rst;
    logic                  req;
    logic                  wr;
    logic [`DC_STRB_W-1:0] sel;
    logic [`DC_ADDR_W-1:0] addr;
    logic [`DC_WORD_W-1:0] wdata;
    logic                  addr_ok;
    logic                  data_ok;
    logic [`DC_WORD_W-1:0] rdata;
    logic [`DC_ADDR_W-1:0] mem_ar_addr;
    logic                  mem_ar_valid;
    logic                  mem_ar_ready;
    logic [`DC_WORD_W-1:0] mem_r_data;
    logic                  mem_r_valid;
    logic                  mem_r_last;
    logic [`DC_ADDR_W-1:0] mem_aw_addr;
    logic                  mem_aw_valid;
    logic                  mem_aw_ready;
    logic [`DC_WORD_W-1:0] mem_w_data;
    logic                  mem_w_valid;
    logic                  mem_w_ready;
    logic                  mem_w_last;
    logic                  mem_b_valid;

    // shadow of the memory as the cpu sees it
    logic [`DC_WORD_W-1:0] shadow [mem_words];
    logic                  exp_read [$];
    logic [`DC_WORD_W-1:0] exp_word [$];
    dcache_addr_u          cur_addr;
    dcache_addr_u          last_aw;
    dcache_addr_u          aw_want;
    logic [13:0]           wb_ptr;
    int                    ar_count;
    int                    aw_count;
    int                    valid_cycles;
    int                    seed;

    dcache_top dcache_top_i (
        .clk(clk), .rst(rst), .req(req), .wr(wr), .sel(sel), .addr(addr), .wdata(wdata),
        .addr_ok(addr_ok), .data_ok(data_ok), .rdata(rdata),
        .mem_ar_addr(mem_ar_addr), .mem_ar_valid(mem_ar_valid), .mem_ar_ready(mem_ar_ready),
        .mem_r_data(mem_r_data), .mem_r_valid(mem_r_valid), .mem_r_last(mem_r_last),
        .mem_aw_addr(mem_aw_addr), .mem_aw_valid(mem_aw_valid), .mem_aw_ready(mem_aw_ready),
        .mem_w_data(mem_w_data), .mem_w_valid(mem_w_valid), .mem_w_ready(mem_w_ready),
        .mem_w_last(mem_w_last), .mem_b_valid(mem_b_valid)
    );

    mem_model mem_model_i (
        .clk(clk), .rst(rst),
        .ar_addr(mem_ar_addr), .ar_valid(mem_ar_valid), .ar_ready(mem_ar_ready),
        .r_data(mem_r_data), .r_valid(mem_r_valid), .r_last(mem_r_last),
        .aw_addr(mem_aw_addr), .aw_valid(mem_aw_valid), .aw_ready(mem_aw_ready),
        .w_data(mem_w_data), .w_valid(mem_w_valid), .w_ready(mem_w_ready),
        .w_last(mem_w_last), .b_valid(mem_b_valid)
    );

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input logic [`DC_WORD_W-1:0] got,
                              input logic [`DC_WORD_W-1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Error: %s is %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input dcache_addr_u got,
                              input dcache_addr_u exp);
        if (got.raw !== exp.raw) begin
            report_failure($sformatf("Error: %s is %h, expected %h", name, got.raw, exp.raw));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("Error: %s is %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            report_failure($sformatf("Error: %s is %h, expected %h", name, got, exp));
        end
    endtask

    function automatic logic [`DC_WORD_W-1:0] fill_pattern(input logic [13:0] widx);
        return {2'b10, widx, 2'b01, widx} ^ 32'h3c5a_0f0f;
    endfunction

    function automatic dcache_addr_u make_addr(input int tag, input int index, input int offset);
        dcache_addr_u a;
        a.f.tag      = `DC_TAG_W'(tag);
        a.f.index    = `DC_INDEX_W'(index);
        a.f.offset   = `DC_OFFSET_W'(offset);
        a.f.byte_off = '0;
        return a;
    endfunction

    function automatic dcache_addr_u line_addr(input dcache_addr_u a);
        dcache_addr_u l;
        l            = a;
        l.f.offset   = '0;
        l.f.byte_off = '0;
        return l;
    endfunction

    function automatic logic [`DC_WORD_W-1:0] merge_bytes(input logic [`DC_WORD_W-1:0] old_w,
                                                          input logic [`DC_WORD_W-1:0] new_w,
                                                          input logic [`DC_STRB_W-1:0] be);
        logic [`DC_WORD_W-1:0] m;
        m = old_w;
        for (int k = 0; k < `DC_STRB_W; k++) begin
            if (be[k]) begin
                m[8*k +: 8] = new_w[8*k +: 8];
            end
        end
        return m;
    endfunction

    // the cache is transparent, so a read returns the shadow word
    function automatic logic [`DC_WORD_W-1:0] expected_word(input dcache_addr_u a);
        return shadow[a.raw[15:2]];
    endfunction

    task automatic access(input logic is_wr, input logic [`DC_STRB_W-1:0] be,
                          input dcache_addr_u a, input logic [`DC_WORD_W-1:0] d,
                          output int lat);
        logic [13:0] widx;
        widx = a.raw[15:2];
        @(posedge clk);
        req   <= 1'b1;
        wr    <= is_wr;
        sel   <= be;
        addr  <= a.raw;
        wdata <= d;
        do begin
            @(negedge clk);
        end while (!addr_ok);
        // accepted on this edge
        @(posedge clk);
        req      <= 1'b0;
        cur_addr  = a;
        exp_read.push_back(!is_wr);
        exp_word.push_back(expected_word(a));
        if (is_wr) begin
            shadow[widx] = merge_bytes(shadow[widx], d, be);
        end
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!data_ok);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        report_failure("watchdog expired before all operations completed");
    end

    // memory bus monitor
    always @(negedge clk) begin
        if (!rst) begin
            if (mem_ar_valid || mem_aw_valid || mem_w_valid) begin
                valid_cycles++;
            end
            if (mem_ar_valid && mem_ar_ready) begin
                ar_count++;
                check_addr("mem_ar_addr", mem_ar_addr, line_addr(cur_addr));
            end
            if (mem_aw_valid && mem_aw_ready) begin
                aw_count++;
                last_aw = mem_aw_addr;
                wb_ptr  = mem_aw_addr[15:2];
                // the victim line sits in the set of the request
                aw_want       = line_addr(cur_addr);
                aw_want.f.tag = last_aw.f.tag;
                check_addr("mem_aw_addr", mem_aw_addr, aw_want);
            end
            // a dirty line holds the latest cpu data
            if (mem_w_valid && mem_w_ready) begin
                check_word("mem_w_data", mem_w_data, shadow[wb_ptr]);
                check_bit("mem_w_last", mem_w_last, wb_ptr[2:0] == 3'd7);
                wb_ptr++;
            end
        end
    end

    always @(negedge clk) begin
        logic                  is_read;
        logic [`DC_WORD_W-1:0] want;
        if (!rst && data_ok) begin
            if (exp_read.size() == 0) begin
                report_failure("data_ok pulsed with no request outstanding");
            end else begin
                is_read = exp_read.pop_front();
                want    = exp_word.pop_front();
                if (is_read) begin
                    check_word("rdata", rdata, want);
                end
            end
        end
    end

    initial begin
        int                    lat;
        int                    ar_before;
        int                    aw_before;
        int                    vc_before;
        logic [31:0]           r;
        logic [`DC_WORD_W-1:0] d_rand;
        dcache_addr_u          a;
        dcache_addr_u          b;
        dcache_addr_u          c;
        dcache_addr_u          d;
        seed         = 32'h9621bcba;
        rst          = 1'b1;
        req          = 1'b0;
        wr           = 1'b0;
        sel          = '0;
        addr         = '0;
        wdata        = '0;
        ar_count     = 0;
        aw_count     = 0;
        valid_cycles = 0;
        wb_ptr       = '0;
        cur_addr     = '0;
        for (int i = 0; i < mem_words; i++) begin
            shadow[i] = fill_pattern(14'(i));
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_bit("addr_ok", addr_ok, 1'b1);
        check_bit("data_ok", data_ok, 1'b0);
        check_bit("mem_ar_valid", mem_ar_valid, 1'b0);
        check_bit("mem_aw_valid", mem_aw_valid, 1'b0);
        check_bit("mem_w_valid", mem_w_valid, 1'b0);

        // read miss, then the same read hits
        a = make_addr(1, 5, 3);
        ar_before = ar_count;
        access(1'b0, 4'hf, a, '0, lat);
        check_count("refill bursts", ar_count - ar_before, 1);
        vc_before = valid_cycles;
        access(1'b0, 4'hf, a, '0, lat);
        check_count("hit latency", lat, 1);
        check_count("memory valid cycles on hit", valid_cycles - vc_before, 0);

        // byte lanes on a hit line and on a write miss
        access(1'b1, 4'b0001, a, 32'h1122_3344, lat);
        access(1'b1, 4'b0110, a, 32'haabb_ccdd, lat);
        access(1'b1, 4'b1000, a, 32'h5566_7788, lat);
        access(1'b0, 4'hf, a, '0, lat);
        b = make_addr(2, 9, 1);
        access(1'b1, 4'b0011, b, 32'hdead_beef, lat);
        access(1'b0, 4'hf, b, '0, lat);
        access(1'b0, 4'hf, make_addr(2, 9, 2), '0, lat);

        // dirty A is evicted by C, clean B by D
        a = make_addr(3, 20, 6);
        b = make_addr(4, 20, 2);
        c = make_addr(5, 20, 4);
        d = make_addr(6, 20, 0);
        access(1'b1, 4'hf, a, 32'h0bad_cafe, lat);
        access(1'b0, 4'hf, b, '0, lat);
        aw_before = aw_count;
        access(1'b0, 4'hf, c, '0, lat);
        check_count("write-back bursts", aw_count - aw_before, 1);
        check_addr("mem_aw_addr", last_aw, line_addr(a));
        aw_before = aw_count;
        access(1'b0, 4'hf, d, '0, lat);
        check_count("write-back bursts on clean eviction", aw_count - aw_before, 0);
        access(1'b0, 4'hf, a, '0, lat);

        // lru order A, B, touch A, then C evicts B
        a = make_addr(7, 40, 1);
        b = make_addr(8, 40, 1);
        c = make_addr(9, 40, 1);
        access(1'b0, 4'hf, a, '0, lat);
        access(1'b0, 4'hf, b, '0, lat);
        access(1'b0, 4'hf, a, '0, lat);
        access(1'b0, 4'hf, c, '0, lat);
        ar_before = ar_count;
        access(1'b0, 4'hf, a, '0, lat);
        check_count("hit latency after lru eviction", lat, 1);
        check_count("refill bursts for kept line", ar_count - ar_before, 0);
        ar_before = ar_count;
        access(1'b0, 4'hf, b, '0, lat);
        check_count("refill bursts for evicted line", ar_count - ar_before, 1);

        // random traffic over 4 sets and 4 tags
        for (int n = 0; n < random_ops; n++) begin
            r      = $random(seed);
            d_rand = $random(seed);
            a      = make_addr(10 + int'(r[3:2]), 60 + int'(r[1:0]), int'(r[6:4]));
            access(r[7], r[11:8] % 4'd15 + 4'd1, a, d_rand, lat);
        end

        @(posedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule
